// File: sim.f
+incdir+source
source/extiPkg.sv
source/apbRegDecoder.sv
source/extiBank.sv
source/irqCombiner.sv
source/extiTop.sv
test/tbClock.sv
test/tbExti.sv

// File: Bender.yml
package:
  name: exti

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/extiPkg.sv
      - source/apbRegDecoder.sv
      - source/extiBank.sv
      - source/irqCombiner.sv
      - source/extiTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tbClock.sv
      - test/tbExti.sv

// File: test/tbExti.sv
`timescale 1ns/1ps
`include "exti_settings.svh"

module tbExti;

    localparam int NumBanks  = `EXTI_NUM_BANKS;
    localparam int Lines     = `EXTI_BANK_LINES;
    localparam int NumLines  = NumBanks * Lines;
    localparam int AddrW     = `EXTI_ADDR_WIDTH;
    localparam int Stride    = `EXTI_BANK_STRIDE;
    localparam int BankWords = Stride / 4;
    localparam int IdAddr    = NumBanks * Stride;
    localparam int Timeout   = 20;

    logic                clk;
    logic                rst_n;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [AddrW-1:0]    paddr;
    extiPkg::word_t      pwdata;
    extiPkg::word_t      prdata;
    logic                pready;
    logic                pslverr;
    logic [NumLines-1:0] pins;
    logic                irq;
    extiPkg::irqId_t     irqId;

    // reference model of the four registers per bank
    extiPkg::word_t      mEnable  [NumBanks];
    extiPkg::word_t      mPending [NumBanks];
    extiPkg::word_t      mRise    [NumBanks];
    extiPkg::word_t      mFall    [NumBanks];
    logic [NumLines-1:0] mPins;

    extiPkg::word_t      expRdata;
    logic                expErr;
    logic                expIrq;
    extiPkg::irqId_t     expId;
    logic                settled;   // irq outputs caught up with the model
    int                  errors;
    int                  timeouts;
    int                  seed;

    tbClock uClock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    extiTop UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pins    (pins),
        .irq     (irq),
        .irqId   (irqId)
    );

    // ======================================================================
    // checks
    // ======================================================================
    readData : assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite) |-> prdata == expRdata
    ) else begin
        errors++;
        $display("FAIL prdata at paddr %h: got %h, expected %h",
                 $sampled(paddr), $sampled(prdata), $sampled(expRdata));
    end

    errResponse : assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> pslverr == expErr
    ) else begin
        errors++;
        $display("FAIL pslverr at paddr %h: got %h, expected %h",
                 $sampled(paddr), $sampled(pslverr), $sampled(expErr));
    end

    irqLevel : assert property (
        @(posedge clk) disable iff (!rst_n)
        settled |-> irq == expIrq
    ) else begin
        errors++;
        $display("FAIL irq: got %h, expected %h", $sampled(irq), $sampled(expIrq));
    end

    irqIdent : assert property (
        @(posedge clk) disable iff (!rst_n)
        settled |-> irqId == expId
    ) else begin
        errors++;
        $display("FAIL irqId: got %h, expected %h", $sampled(irqId), $sampled(expId));
    end

    // ======================================================================
    // model helpers
    // ======================================================================
    function automatic extiPkg::word_t qualifiedEdges(input int b,
                                                      input logic [NumLines-1:0] was,
                                                      input logic [NumLines-1:0] now);
        extiPkg::word_t oldW;
        extiPkg::word_t newW;
        oldW = was[b*Lines +: Lines];
        newW = now[b*Lines +: Lines];
        return (newW & ~oldW & mRise[b]) | (~newW & oldW & mFall[b]);
    endfunction

    task automatic refreshExpected();
        expIrq = 1'b0;
        expId  = '0;
        for (int n = 0; n < NumLines && !expIrq; n++) begin
            if (mPending[n / Lines][n % Lines] && mEnable[n / Lines][n % Lines]) begin
                expIrq      = 1'b1;
                expId.valid = 1'b1;
                expId.line  = extiPkg::lineId_t'(n);
            end
        end
    endtask

    function automatic extiPkg::word_t modelRead(input int addr);
        extiPkg::word_t idWord;
        int             word;
        int             b;
        word = addr / 4;
        b    = word / BankWords;
        idWord = '0;
        idWord[Lines-1] = expId.valid;
        idWord[extiPkg::LineIdWidth-1:0] = expId.line;
        if (word == IdAddr / 4) return idWord;
        if (word > IdAddr / 4) return '0;
        case (word % BankWords)
            `EXTI_REG_ENABLE:                       return mEnable[b];
            `EXTI_REG_PEND_CLR, `EXTI_REG_PEND_SET: return mPending[b];
            `EXTI_REG_RISE_EN:                      return mRise[b];
            `EXTI_REG_FALL_EN:                      return mFall[b];
            default:                                return '0;   // reserved
        endcase
    endfunction

    // ======================================================================
    // bus and pin drivers
    // ======================================================================
    task automatic waitReady();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!pready && waited < Timeout);
        if (!pready) begin
            timeouts++;
            $display("APB slave did not raise pready within %0d cycles", Timeout);
        end
    endtask

    task automatic waitIrq();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!(irq === expIrq && irqId === expId) && waited < Timeout);
        if (irq === expIrq && irqId === expId) begin
            settled = 1'b1;
        end else begin
            timeouts++;
            $display("irq and irqId did not reach the model state within %0d cycles",
                     Timeout);
        end
    endtask

    task automatic apbRead(input int addr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= AddrW'(addr);
        @(posedge clk);
        penable <= 1'b1;
        expRdata = modelRead(addr);
        expErr   = (addr / 4) > (IdAddr / 4);
        waitReady();
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // pins may change on the setup edge so an edge meets the write
    task automatic apbWrite(input int addr, input extiPkg::word_t data,
                            input logic movePins, input logic [NumLines-1:0] newPins);
        extiPkg::word_t edges [NumBanks];
        int             word;
        int             b;
        settled = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= AddrW'(addr);
        pwdata  <= data;
        if (movePins) begin
            pins <= newPins;
        end
        @(posedge clk);
        penable <= 1'b1;
        expErr = (addr / 4) > (IdAddr / 4);
        waitReady();
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        // edges use the edge enables from before the write
        for (int i = 0; i < NumBanks; i++) begin
            edges[i]    = movePins ? qualifiedEdges(i, mPins, newPins) : '0;
            mPending[i] = mPending[i] | edges[i];
        end
        word = addr / 4;
        if (word < IdAddr / 4) begin
            b = word / BankWords;
            case (word % BankWords)
                `EXTI_REG_ENABLE:   mEnable[b]  = data;
                `EXTI_REG_PEND_CLR: mPending[b] = mPending[b] & ~data;
                `EXTI_REG_PEND_SET: mPending[b] = mPending[b] | data;
                `EXTI_REG_RISE_EN:  mRise[b]    = data;
                `EXTI_REG_FALL_EN:  mFall[b]    = data;
                default: ;
            endcase
        end
        if (movePins) begin
            mPins = newPins;
        end
        refreshExpected();
        waitIrq();
    endtask

    task automatic drivePins(input logic [NumLines-1:0] newPins);
        settled = 1'b0;
        @(posedge clk);
        pins <= newPins;
        for (int i = 0; i < NumBanks; i++) begin
            mPending[i] = mPending[i] | qualifiedEdges(i, mPins, newPins);
        end
        mPins = newPins;
        refreshExpected();
        repeat (3) @(posedge clk);   // capture, edge, pending
        waitIrq();
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    initial begin
        int                  waited;
        logic [NumLines-1:0] p;
        extiPkg::word_t      data;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pins     = '0;
        mPins    = '0;
        expRdata = '0;
        expErr   = 1'b0;
        settled  = 1'b0;
        errors   = 0;
        timeouts = 0;
        seed     = 32'hbd0e6663;
        for (int b = 0; b < NumBanks; b++) begin
            mEnable[b]  = '0;
            mPending[b] = '0;
            mRise[b]    = '0;
            mFall[b]    = '0;
        end
        refreshExpected();

        waited = 0;
        while (rst_n !== 1'b1 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end
        waitIrq();

        // everything reads zero out of reset
        for (int a = 0; a <= IdAddr; a += 4) apbRead(a);

        // readback, reserved words and a bad address
        for (int b = 0; b < NumBanks; b++) begin
            apbWrite(b*Stride + `EXTI_REG_ENABLE*4, $random(seed), 1'b0, '0);
            apbWrite(b*Stride + `EXTI_REG_RISE_EN*4, $random(seed), 1'b0, '0);
            apbWrite(b*Stride + `EXTI_REG_FALL_EN*4, $random(seed), 1'b0, '0);
            for (int r = 0; r < BankWords; r++) apbRead(b*Stride + r*4);
        end
        apbWrite(IdAddr + 4, $random(seed), 1'b0, '0);
        apbRead(IdAddr + 4);
        apbRead((1 << AddrW) - 4);
        for (int a = 0; a < IdAddr; a += 4) apbRead(a);

        // edge qualification, bank 0 runs none, rise only, fall only
        for (int cfg = 0; cfg < 3; cfg++) begin
            apbWrite(`EXTI_REG_RISE_EN*4, (cfg == 1) ? $random(seed) : 0, 1'b0, '0);
            apbWrite(`EXTI_REG_FALL_EN*4, (cfg == 2) ? $random(seed) : 0, 1'b0, '0);
            for (int i = 0; i < 4; i++) begin
                for (int b = 0; b < NumBanks; b++) p[b*Lines +: Lines] = $random(seed);
                drivePins(p);
                for (int b = 0; b < NumBanks; b++) apbRead(b*Stride + `EXTI_REG_PEND_CLR*4);
            end
            for (int b = 0; b < NumBanks; b++) begin
                apbWrite(b*Stride + `EXTI_REG_PEND_CLR*4, '1, 1'b0, '0);
            end
        end

        // software set and clear
        for (int b = 0; b < NumBanks; b++) begin
            apbWrite(b*Stride + `EXTI_REG_PEND_SET*4, $random(seed), 1'b0, '0);
            apbRead(b*Stride + `EXTI_REG_PEND_SET*4);
            apbWrite(b*Stride + `EXTI_REG_PEND_CLR*4, $random(seed), 1'b0, '0);
            apbRead(b*Stride + `EXTI_REG_PEND_CLR*4);
        end

        // clear on the same edge as a qualified edge, every bank 0 line toggles
        apbWrite(`EXTI_REG_RISE_EN*4, '1, 1'b0, '0);
        apbWrite(`EXTI_REG_FALL_EN*4, '1, 1'b0, '0);
        p = mPins;
        p[Lines-1:0] = ~mPins[Lines-1:0];
        data = $random(seed);
        apbWrite(`EXTI_REG_PEND_CLR*4, data, 1'b1, p);
        apbRead(`EXTI_REG_PEND_CLR*4);

        // ======================================================================
        // irq and lowest line id
        // ======================================================================
        for (int b = 0; b < NumBanks; b++) begin
            apbWrite(b*Stride + `EXTI_REG_PEND_CLR*4, '1, 1'b0, '0);
            apbWrite(b*Stride + `EXTI_REG_ENABLE*4, '0, 1'b0, '0);
        end
        apbWrite(Stride + `EXTI_REG_ENABLE*4, 32'h0000_0021, 1'b0, '0);
        apbWrite(`EXTI_REG_ENABLE*4, 32'h0010_0000, 1'b0, '0);
        apbWrite(Stride + `EXTI_REG_PEND_SET*4, 32'h0000_0020, 1'b0, '0);
        apbRead(IdAddr);
        apbWrite(`EXTI_REG_PEND_SET*4, 32'h0010_0000, 1'b0, '0);   // lower line wins
        apbRead(IdAddr);
        apbWrite(`EXTI_REG_PEND_CLR*4, 32'h0010_0000, 1'b0, '0);
        apbRead(IdAddr);
        // line 32 qualifies in either direction
        apbWrite(Stride + `EXTI_REG_RISE_EN*4, 32'h0000_0001, 1'b0, '0);
        apbWrite(Stride + `EXTI_REG_FALL_EN*4, 32'h0000_0001, 1'b0, '0);
        p = mPins;
        p[Lines] = ~mPins[Lines];
        drivePins(p);
        apbRead(IdAddr);
        apbWrite(Stride + `EXTI_REG_PEND_CLR*4, '1, 1'b0, '0);
        apbRead(IdAddr);

        for (int i = 0; i < 4; i++) begin
            for (int b = 0; b < NumBanks; b++) begin
                apbWrite(b*Stride + `EXTI_REG_ENABLE*4, $random(seed), 1'b0, '0);
                apbWrite(b*Stride + `EXTI_REG_PEND_SET*4, $random(seed) & $random(seed),
                         1'b0, '0);
            end
            apbRead(IdAddr);
            for (int b = 0; b < NumBanks; b++) begin
                apbWrite(b*Stride + `EXTI_REG_PEND_CLR*4, '1, 1'b0, '0);
            end
            apbRead(IdAddr);
        end

        repeat (2) @(posedge clk);
        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst_n
);

    localparam int HalfPeriod  = 5;   // ns
    localparam int ResetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: source/extiTop.sv
`timescale 1ns/1ps
`include "exti_settings.svh"

module extiTop (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [`EXTI_ADDR_WIDTH-1:0]                   paddr,
    input  extiPkg::word_t                                pwdata,
    output extiPkg::word_t                                prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    input  logic [`EXTI_NUM_BANKS*`EXTI_BANK_LINES-1:0]   pins,
    output logic                                          irq,
    output extiPkg::irqId_t                               irqId
);

    extiPkg::bankWrite_t                       bankWrite;
    logic [`EXTI_NUM_BANKS-1:0]                bankSel;
    extiPkg::bankState_t [`EXTI_NUM_BANKS-1:0] bankState;

    // ======================================================================
    // APB side
    // ======================================================================
    apbRegDecoder uDecoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .bankWrite (bankWrite),
        .bankSel   (bankSel),
        .bankState (bankState),
        .irqId     (irqId)
    );

    // ======================================================================
    // line banks
    // ======================================================================
    for (genvar b = 0; b < `EXTI_NUM_BANKS; b++) begin : gBank
        extiBank uBank (
            .clk       (clk),
            .rst_n     (rst_n),
            .pins      (pins[b*`EXTI_BANK_LINES +: `EXTI_BANK_LINES]),
            .bankWrite (bankWrite),
            .sel       (bankSel[b]),
            .state     (bankState[b])
        );
    end

    // ======================================================================
    // interrupt output
    // ======================================================================
    irqCombiner uCombiner (
        .clk       (clk),
        .rst_n     (rst_n),
        .bankState (bankState),
        .irq       (irq),
        .irqId     (irqId)
    );

endmodule

// File: source/irqCombiner.sv
`timescale 1ns/1ps
`include "exti_settings.svh"

module irqCombiner (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  extiPkg::bankState_t [`EXTI_NUM_BANKS-1:0] bankState,
    output logic                                      irq,
    output extiPkg::irqId_t                           irqId
);

    extiPkg::word_t  active [`EXTI_NUM_BANKS];
    logic            anyActive;
    logic            anyHit;
    extiPkg::lineId_t lowLine;
    logic            irqQ;
    extiPkg::irqId_t idQ;

    // ======================================================================
    // lowest active line
    // ======================================================================
    always_comb begin
        anyActive = 1'b0;
        for (int b = 0; b < `EXTI_NUM_BANKS; b++) begin
            active[b] = bankState[b].pending & bankState[b].enable;
            anyActive = anyActive | (|active[b]);   // plain OR over all lines
        end
    end

    always_comb begin
        anyHit  = 1'b0;
        lowLine = '0;
        // walk down so the lowest hit is the last one kept
        for (int b = `EXTI_NUM_BANKS - 1; b >= 0; b--) begin
            for (int k = `EXTI_BANK_LINES - 1; k >= 0; k--) begin
                if (active[b][k]) begin
                    anyHit  = 1'b1;
                    lowLine = extiPkg::lineId_t'(b * `EXTI_BANK_LINES + k);
                end
            end
        end
    end

    // ======================================================================
    // output registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irqQ      <= 1'b0;
            idQ.valid <= 1'b0;
            idQ.line  <= '0;
        end else begin
            irqQ      <= anyActive;
            idQ.valid <= anyHit;
            idQ.line  <= lowLine;   // don't care when not valid
        end
    end

    assign irq   = irqQ;
    assign irqId = idQ;

    irqMatchesValid : assert property (
        @(posedge clk) disable iff (!rst_n)
        irq == irqId.valid
    ) else $error("irq and irqId.valid disagree");

endmodule

// File: source/extiBank.sv
`timescale 1ns/1ps
`include "exti_settings.svh"

module extiBank (
    input  logic                clk,
    input  logic                rst_n,
    input  extiPkg::word_t      pins,
    input  extiPkg::bankWrite_t bankWrite,
    input  logic                sel,
    output extiPkg::bankState_t state
);

    extiPkg::word_t      capture;
    extiPkg::word_t      previous;
    extiPkg::word_t      rising;
    extiPkg::word_t      falling;
    extiPkg::word_t      edgeHit;
    extiPkg::word_t      setBits;
    extiPkg::word_t      clrBits;
    extiPkg::word_t      pendingNext;
    extiPkg::bankState_t stateQ;
    logic                wrEn;

    // ======================================================================
    // edge detection
    // ======================================================================
    assign rising  =  capture & ~previous;
    assign falling = ~capture &  previous;
    assign edgeHit = (rising & stateQ.riseEn) | (falling & stateQ.fallEn);

    assign wrEn = sel && bankWrite.strobe;

    always_comb begin
        setBits = '0;
        clrBits = '0;
        if (wrEn && bankWrite.regSel == extiPkg::regSel_t'(`EXTI_REG_PEND_SET)) begin
            setBits = bankWrite.data;
        end
        if (wrEn && bankWrite.regSel == extiPkg::regSel_t'(`EXTI_REG_PEND_CLR)) begin
            clrBits = bankWrite.data;
        end
    end

    // clear beats a same-cycle edge
    assign pendingNext = (stateQ.pending | edgeHit | setBits) & ~clrBits;

    // ======================================================================
    // registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            capture  <= '0;
            previous <= '0;
            stateQ   <= '0;
        end else begin
            capture        <= pins;         // single capture stage
            previous       <= capture;
            stateQ.pending <= pendingNext;
            if (wrEn) begin
                case (bankWrite.regSel)
                    extiPkg::regSel_t'(`EXTI_REG_ENABLE): begin
                        stateQ.enable <= bankWrite.data;
                    end
                    extiPkg::regSel_t'(`EXTI_REG_RISE_EN): begin
                        stateQ.riseEn <= bankWrite.data;
                    end
                    extiPkg::regSel_t'(`EXTI_REG_FALL_EN): begin
                        stateQ.fallEn <= bankWrite.data;
                    end
                    default: begin
                        // pending handled above, reserved ignored
                    end
                endcase
            end
        end
    end

    assign state = stateQ;

    // a pending bit only rises from an edge, a set write, or if already set
    pendingSource : assert property (
        @(posedge clk) disable iff (!rst_n)
        (stateQ.pending & ~$past(stateQ.pending
            | (capture & ~previous & stateQ.riseEn)
            | (~capture & previous & stateQ.fallEn)
            | ((sel && bankWrite.strobe
                && bankWrite.regSel == extiPkg::regSel_t'(`EXTI_REG_PEND_SET))
               ? bankWrite.data : '0))) == '0
    ) else $error("pending bit set without a source");

endmodule

// File: source/apbRegDecoder.sv
`timescale 1ns/1ps
`include "exti_settings.svh"

module apbRegDecoder (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [`EXTI_ADDR_WIDTH-1:0]                   paddr,
    input  extiPkg::word_t                                pwdata,
    output extiPkg::word_t                                prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    output extiPkg::bankWrite_t                           bankWrite,
    output logic [`EXTI_NUM_BANKS-1:0]                    bankSel,
    input  extiPkg::bankState_t [`EXTI_NUM_BANKS-1:0]     bankState,
    input  extiPkg::irqId_t                               irqId
);

    localparam int StrideBits = $clog2(`EXTI_BANK_STRIDE);
    localparam int BankIdxW   = `EXTI_ADDR_WIDTH - StrideBits;
    localparam int WordIdxW   = `EXTI_ADDR_WIDTH - 2;
    localparam int IdWord     = `EXTI_NUM_BANKS * (`EXTI_BANK_STRIDE / 4);

    logic                  access;
    logic [WordIdxW-1:0]   wordIdx;
    logic [BankIdxW-1:0]   bankIdx;
    extiPkg::regSel_t      regSel;
    logic                  inBanks;
    logic                  isId;
    logic                  badAddr;
    extiPkg::bankState_t   selState;

    // ======================================================================
    // address split
    // ======================================================================
    assign access  = psel && penable;          // single access cycle, no waits
    assign wordIdx = paddr[`EXTI_ADDR_WIDTH-1:2];
    assign bankIdx = paddr[`EXTI_ADDR_WIDTH-1:StrideBits];
    assign regSel  = paddr[StrideBits-1:2];

    assign inBanks = wordIdx < WordIdxW'(IdWord);
    assign isId    = wordIdx == WordIdxW'(IdWord);
    assign badAddr = wordIdx > WordIdxW'(IdWord);

    assign pready  = 1'b1;
    assign pslverr = access && badAddr;

    always_comb begin
        for (int b = 0; b < `EXTI_NUM_BANKS; b++) begin
            bankSel[b] = inBanks && (bankIdx == BankIdxW'(b));
        end
    end

    // ======================================================================
    // write broadcast
    // ======================================================================
    assign bankWrite.strobe = access && pwrite && inBanks;
    assign bankWrite.regSel = regSel;
    assign bankWrite.data   = pwdata;

    // ======================================================================
    // read mux
    // ======================================================================
    always_comb begin
        selState = '0;
        for (int b = 0; b < `EXTI_NUM_BANKS; b++) begin
            if (bankSel[b]) begin
                selState = bankState[b];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (access && isId) begin
            // valid in bit 31, line number at the bottom
            prdata[`EXTI_BANK_LINES-1]           = irqId.valid;
            prdata[extiPkg::LineIdWidth-1:0]     = irqId.line;
        end else if (access && inBanks) begin
            case (regSel)
                extiPkg::regSel_t'(`EXTI_REG_ENABLE):   prdata = selState.enable;
                extiPkg::regSel_t'(`EXTI_REG_PEND_CLR): prdata = selState.pending;
                extiPkg::regSel_t'(`EXTI_REG_PEND_SET): prdata = selState.pending;
                extiPkg::regSel_t'(`EXTI_REG_RISE_EN):  prdata = selState.riseEn;
                extiPkg::regSel_t'(`EXTI_REG_FALL_EN):  prdata = selState.fallEn;
                default:                                 prdata = '0; // reserved
            endcase
        end
    end

    // ======================================================================
    // bus protocol checks
    // ======================================================================
    penableAfterSetup : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable)
    ) else $error("penable rose without a setup phase");

    paddrStable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && penable) |-> $stable(paddr)
    ) else $error("paddr changed between setup and access");

endmodule

// File: source/extiPkg.sv
`include "exti_settings.svh"

package extiPkg;

    // ======================================================================
    // widths with a meaning
    // ======================================================================
    localparam int LineIdWidth = $clog2(`EXTI_NUM_BANKS * `EXTI_BANK_LINES);

    typedef logic [`EXTI_BANK_LINES-1:0] word_t;   // APB data, one bank of lines
    typedef logic [2:0]                  regSel_t; // word offset in a bank
    typedef logic [LineIdWidth-1:0]      lineId_t; // global line number

    // ======================================================================
    // structs between decoder, banks and combiner
    // ======================================================================

    // write broadcast to all banks
    typedef struct packed {
        logic    strobe;
        regSel_t regSel;
        word_t   data;
    } bankWrite_t;

    // register contents of one bank
    typedef struct packed {
        word_t enable;
        word_t pending;
        word_t riseEn;
        word_t fallEn;
    } bankState_t;

    // lowest pending and enabled line
    typedef struct packed {
        logic    valid;
        lineId_t line;
    } irqId_t;

endpackage

// File: source/exti_settings.svh
`ifndef EXTI_SETTINGS_SVH
`define EXTI_SETTINGS_SVH

// ==========================================================================
// controller sizing
// ==========================================================================
`define EXTI_NUM_BANKS   2
`define EXTI_BANK_LINES  32    // one APB word per bank
`define EXTI_ADDR_WIDTH  12
`define EXTI_BANK_STRIDE 32    // bytes, eight words per bank

// word offsets inside a bank, 5..7 reserved
`define EXTI_REG_ENABLE   0
`define EXTI_REG_PEND_CLR 1
`define EXTI_REG_PEND_SET 2
`define EXTI_REG_RISE_EN  3
`define EXTI_REG_FALL_EN  4

`endif
